// File: verilog/id_consts.svh
// Decode stage constants
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// Datapath widths fixed by RV32
`define ID_ILEN   32
`define ID_XLEN   32
`define ID_REG_W  5
`define ID_PC_W   32

// Compressed halfword width
`define ID_CLEN   16

// Quadrant bits, 2'b11 marks a full-width instruction
`define ID_C_MARK_MSB 1
`define ID_C_MARK_LSB 0

`endif

// File: verilog/riscv_pkg.sv
// RV32 instruction set encodings
package riscv_pkg;

  // --------------------
  // Major opcodes
  // --------------------
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // --------------------
  // Compressed quadrants
  // --------------------
  typedef enum logic [1:0] {
    C_Q0   = 2'b00,
    C_Q1   = 2'b01,
    C_Q2   = 2'b10,
    C_NONE = 2'b11
  } c_quad_e;

endpackage

// File: verilog/id_pkg.sv
// Decode result types
package id_pkg;

  // Functional unit that executes the entry
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LOAD,
    FU_STORE
  } fu_e;

  // --------------------
  // Operations
  // --------------------
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR,
    OP_XOR, OP_SLL, OP_SRL, OP_SRA,
    OP_SLT, OP_SLTU,
    OP_LUI, OP_AUIPC,
    OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
    OP_LW, OP_SW,
    OP_NOP
  } op_e;

endpackage

// File: verilog/compressed_expander.sv
// Compressed instruction expander
`timescale 1ns/1ns
`include "id_consts.svh"

module compressed_expander (
  input  logic [`ID_ILEN-1:0] instr_i,
  output logic [`ID_ILEN-1:0] instr_o,
  output logic                is_compressed_o,
  output logic                illegal_o
);
  import riscv_pkg::*;

  logic [`ID_CLEN-1:0]  c;
  c_quad_e              quad;
  logic [`ID_REG_W-1:0] rd_f;
  logic [`ID_REG_W-1:0] rs2_f;
  logic [`ID_REG_W-1:0] rs1_p;
  logic [`ID_REG_W-1:0] rd_p;

  assign c     = instr_i[`ID_CLEN-1:0];
  assign quad  = c_quad_e'(instr_i[`ID_C_MARK_MSB:`ID_C_MARK_LSB]);
  assign rd_f  = c[11:7];
  assign rs2_f = c[6:2];
  // Popular registers x8..x15
  assign rs1_p = {2'b01, c[9:7]};
  assign rd_p  = {2'b01, c[4:2]};

  assign is_compressed_o = (quad != C_NONE);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      // Anything not matched below stays illegal
      instr_o   = '0;
      illegal_o = 1'b1;
      case (quad)
        C_Q0: begin
          if (c[15:13] == 3'b010) begin
            // C.LW
            instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p, OPC_LOAD};
            illegal_o = 1'b0;
          end else if (c[15:13] == 3'b110) begin
            // C.SW
            instr_o   = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010, c[11:10], c[6], 2'b00,
                         OPC_STORE};
            illegal_o = 1'b0;
          end
        end
        C_Q1: begin
          illegal_o = 1'b0;
          case (c[15:13])
            3'b000: instr_o = {{7{c[12]}}, c[6:2], rd_f, 3'b000, rd_f, OPC_OP_IMM};
            3'b010: instr_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd_f, OPC_OP_IMM};
            // C.J becomes jal x0
            3'b101: instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                               c[12], {8{c[12]}}, 5'd0, OPC_JAL};
            // C.BEQZ compares against x0
            3'b110: instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1_p, 3'b000,
                               c[11:10], c[4:3], c[12], OPC_BRANCH};
            default: illegal_o = 1'b1;
          endcase
        end
        C_Q2: begin
          // rs2 of zero would be C.JR / C.JALR, not supported
          if (c[15:13] == 3'b100 && rs2_f != '0) begin
            instr_o   = {7'b0, rs2_f, c[12] ? rd_f : 5'd0, 3'b000, rd_f, OPC_OP};
            illegal_o = 1'b0;
          end
        end
        default: illegal_o = 1'b1;
      endcase
      // The zero halfword is defined illegal
      if (c == '0) begin
        illegal_o = 1'b1;
      end
    end
  end

endmodule

// File: verilog/instr_decoder.sv
// RV32I subset decoder
`timescale 1ns/1ns
`include "id_consts.svh"

module instr_decoder (
  input  logic [`ID_ILEN-1:0]  instr_i,
  input  logic                 illegal_i,
  output id_pkg::fu_e          fu_o,
  output id_pkg::op_e          op_o,
  output logic [`ID_REG_W-1:0] rs1_o,
  output logic [`ID_REG_W-1:0] rs2_o,
  output logic [`ID_REG_W-1:0] rd_o,
  output logic [`ID_XLEN-1:0]  imm_o,
  output logic                 illegal_o,
  output logic                 ctrl_flow_o
);
  import riscv_pkg::*;
  import id_pkg::*;

  opcode_e              opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`ID_REG_W-1:0] rs1_f;
  logic [`ID_REG_W-1:0] rs2_f;
  logic [`ID_REG_W-1:0] rd_f;
  logic [`ID_XLEN-1:0]  imm_i_t;
  logic [`ID_XLEN-1:0]  imm_s_t;
  logic [`ID_XLEN-1:0]  imm_b_t;
  logic [`ID_XLEN-1:0]  imm_u_t;
  logic [`ID_XLEN-1:0]  imm_j_t;
  logic                 unknown;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_f   = instr_i[11:7];
  assign rs1_f  = instr_i[19:15];
  assign rs2_f  = instr_i[24:20];

  // --------------------
  // Immediate formats
  // --------------------
  assign imm_i_t = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_t = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_t = {{(`ID_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
  assign imm_u_t = {instr_i[31:12], 12'b0};
  assign imm_j_t = {{(`ID_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

  always_comb begin
    fu_o        = FU_NONE;
    op_o        = OP_NOP;
    rs1_o       = '0;
    rs2_o       = '0;
    rd_o        = '0;
    imm_o       = '0;
    ctrl_flow_o = 1'b0;
    unknown     = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        fu_o  = FU_ALU;
        op_o  = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
        rd_o  = rd_f;
        imm_o = imm_u_t;
      end
      OPC_JAL: begin
        fu_o        = FU_BRANCH;
        op_o        = OP_JAL;
        rd_o        = rd_f;
        imm_o       = imm_j_t;
        ctrl_flow_o = 1'b1;
      end
      OPC_JALR: begin
        fu_o        = FU_BRANCH;
        op_o        = OP_JALR;
        rs1_o       = rs1_f;
        rd_o        = rd_f;
        imm_o       = imm_i_t;
        ctrl_flow_o = 1'b1;
        unknown     = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        fu_o        = FU_BRANCH;
        rs1_o       = rs1_f;
        rs2_o       = rs2_f;
        imm_o       = imm_b_t;
        ctrl_flow_o = 1'b1;
        case (funct3)
          3'b000:  op_o = OP_BEQ;
          3'b001:  op_o = OP_BNE;
          3'b100:  op_o = OP_BLT;
          3'b101:  op_o = OP_BGE;
          default: unknown = 1'b1;
        endcase
      end
      // Only word accesses
      OPC_LOAD: begin
        fu_o    = FU_LOAD;
        op_o    = OP_LW;
        rs1_o   = rs1_f;
        rd_o    = rd_f;
        imm_o   = imm_i_t;
        unknown = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        fu_o    = FU_STORE;
        op_o    = OP_SW;
        rs1_o   = rs1_f;
        rs2_o   = rs2_f;
        imm_o   = imm_s_t;
        unknown = (funct3 != 3'b010);
      end
      OPC_OP_IMM, OPC_OP: begin
        fu_o  = FU_ALU;
        rs1_o = rs1_f;
        rd_o  = rd_f;
        if (opcode == OPC_OP) begin
          rs2_o = rs2_f;
        end else begin
          imm_o = imm_i_t;
        end
        case (funct3)
          3'b000: op_o = (opcode == OPC_OP && funct7 == 7'b0100000) ? OP_SUB : OP_ADD;
          3'b001: op_o = OP_SLL;
          3'b010: op_o = OP_SLT;
          3'b011: op_o = OP_SLTU;
          3'b100: op_o = OP_XOR;
          3'b101: op_o = (funct7 == 7'b0100000) ? OP_SRA : OP_SRL;
          3'b110: op_o = OP_OR;
          default: op_o = OP_AND;
        endcase
        // funct7 only matters for R-type and shifts
        if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
          if (funct7 == 7'b0100000) begin
            unknown = !(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP));
          end else begin
            unknown = (funct7 != 7'b0);
          end
        end
      end
      default: unknown = 1'b1;
    endcase
    if (unknown || illegal_i) begin
      fu_o        = FU_NONE;
      op_o        = OP_NOP;
      rs1_o       = '0;
      rs2_o       = '0;
      rd_o        = '0;
      imm_o       = '0;
      ctrl_flow_o = 1'b0;
    end
  end

  assign illegal_o = unknown || illegal_i;

endmodule

// File: verilog/issue_register.sv
// ID/issue pipeline register
`timescale 1ns/1ns
`include "id_consts.svh"

module issue_register (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  input  logic                 issue_ack_i,
  input  logic [`ID_PC_W-1:0]  pc_i,
  input  logic [`ID_ILEN-1:0]  orig_instr_i,
  input  logic                 is_compressed_i,
  input  id_pkg::fu_e          fu_i,
  input  id_pkg::op_e          op_i,
  input  logic [`ID_REG_W-1:0] rs1_i,
  input  logic [`ID_REG_W-1:0] rs2_i,
  input  logic [`ID_REG_W-1:0] rd_i,
  input  logic [`ID_XLEN-1:0]  imm_i,
  input  logic                 illegal_i,
  input  logic                 ctrl_flow_i,
  output logic                 fetch_ready_o,
  output logic                 issue_valid_o,
  output logic [`ID_PC_W-1:0]  pc_o,
  output logic [`ID_ILEN-1:0]  orig_instr_o,
  output logic                 is_compressed_o,
  output id_pkg::fu_e          fu_o,
  output id_pkg::op_e          op_o,
  output logic [`ID_REG_W-1:0] rs1_o,
  output logic [`ID_REG_W-1:0] rs2_o,
  output logic [`ID_REG_W-1:0] rd_o,
  output logic [`ID_XLEN-1:0]  imm_o,
  output logic                 illegal_o,
  output logic                 ctrl_flow_o
);
  import id_pkg::*;

  logic valid_q;
  logic accept;

  // Room when empty or when the entry leaves this cycle
  assign fetch_ready_o = !valid_q || issue_ack_i;
  assign accept        = fetch_valid_i && fetch_ready_o;
  assign issue_valid_o = valid_q;

  // --------------------
  // Valid bit
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, loaded on every accepted word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_o            <= '0;
      orig_instr_o    <= '0;
      is_compressed_o <= 1'b0;
      fu_o            <= FU_NONE;
      op_o            <= OP_NOP;
      rs1_o           <= '0;
      rs2_o           <= '0;
      rd_o            <= '0;
      imm_o           <= '0;
      illegal_o       <= 1'b0;
      ctrl_flow_o     <= 1'b0;
    end else if (accept) begin
      pc_o            <= pc_i;
      // Upper half of a compressed word is the next instruction
      orig_instr_o    <= is_compressed_i ?
                         {{(`ID_ILEN-`ID_CLEN){1'b0}}, orig_instr_i[`ID_CLEN-1:0]} :
                         orig_instr_i;
      is_compressed_o <= is_compressed_i;
      fu_o            <= fu_i;
      op_o            <= op_i;
      rs1_o           <= rs1_i;
      rs2_o           <= rs2_i;
      rd_o            <= rd_i;
      imm_o           <= imm_i;
      illegal_o       <= illegal_i;
      ctrl_flow_o     <= ctrl_flow_i;
    end
  end

endmodule

// File: verilog/id_stage.sv
// Instruction decode stage
`timescale 1ns/1ns
`include "id_consts.svh"

module id_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  input  logic [`ID_ILEN-1:0]  fetch_instr_i,
  input  logic [`ID_PC_W-1:0]  fetch_pc_i,
  output logic                 fetch_ready_o,
  input  logic                 issue_ack_i,
  output logic                 issue_valid_o,
  output logic [`ID_PC_W-1:0]  issue_pc_o,
  output id_pkg::fu_e          issue_fu_o,
  output id_pkg::op_e          issue_op_o,
  output logic [`ID_REG_W-1:0] issue_rs1_o,
  output logic [`ID_REG_W-1:0] issue_rs2_o,
  output logic [`ID_REG_W-1:0] issue_rd_o,
  output logic [`ID_XLEN-1:0]  issue_imm_o,
  output logic                 issue_illegal_o,
  output logic                 issue_ctrl_flow_o,
  output logic                 issue_compressed_o,
  output logic [`ID_ILEN-1:0]  orig_instr_o
);
  import id_pkg::*;

  logic [`ID_ILEN-1:0]  exp_instr;
  logic                 exp_compressed;
  logic                 exp_illegal;
  fu_e                  dec_fu;
  op_e                  dec_op;
  logic [`ID_REG_W-1:0] dec_rs1;
  logic [`ID_REG_W-1:0] dec_rs2;
  logic [`ID_REG_W-1:0] dec_rd;
  logic [`ID_XLEN-1:0]  dec_imm;
  logic                 dec_illegal;
  logic                 dec_ctrl_flow;

  compressed_expander u_expander (
    .instr_i         (fetch_instr_i),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  instr_decoder u_decoder (
    .instr_i     (exp_instr),
    .illegal_i   (exp_illegal),
    .fu_o        (dec_fu),
    .op_o        (dec_op),
    .rs1_o       (dec_rs1),
    .rs2_o       (dec_rs2),
    .rd_o        (dec_rd),
    .imm_o       (dec_imm),
    .illegal_o   (dec_illegal),
    .ctrl_flow_o (dec_ctrl_flow)
  );

  issue_register u_issue_reg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_valid_i   (fetch_valid_i),
    .issue_ack_i     (issue_ack_i),
    .pc_i            (fetch_pc_i),
    .orig_instr_i    (fetch_instr_i),
    .is_compressed_i (exp_compressed),
    .fu_i            (dec_fu),
    .op_i            (dec_op),
    .rs1_i           (dec_rs1),
    .rs2_i           (dec_rs2),
    .rd_i            (dec_rd),
    .imm_i           (dec_imm),
    .illegal_i       (dec_illegal),
    .ctrl_flow_i     (dec_ctrl_flow),
    .fetch_ready_o   (fetch_ready_o),
    .issue_valid_o   (issue_valid_o),
    .pc_o            (issue_pc_o),
    .orig_instr_o    (orig_instr_o),
    .is_compressed_o (issue_compressed_o),
    .fu_o            (issue_fu_o),
    .op_o            (issue_op_o),
    .rs1_o           (issue_rs1_o),
    .rs2_o           (issue_rs2_o),
    .rd_o            (issue_rd_o),
    .imm_o           (issue_imm_o),
    .illegal_o       (issue_illegal_o),
    .ctrl_flow_o     (issue_ctrl_flow_o)
  );

endmodule

// File: sim/id_assertions.sv
// Handshake checks on the decode stage
`timescale 1ns/1ns

module id_assertions (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        flush_i,
  input logic        valid_i,
  input logic        ack_i,
  input logic        ready_i,
  input logic [31:0] pc_i,
  input logic [31:0] instr_i
);

  a_reset_empty: assert property (@(posedge clk_i) !rst_ni |-> !valid_i)
    else $error("issue valid high during reset");

  // Held entry must not change until acknowledged
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ack_i && !flush_i) |=> (valid_i && $stable(pc_i) && $stable(instr_i)))
    else $error("held entry changed without ack");

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_i == (!valid_i || ack_i))
    else $error("fetch ready does not follow valid and ack");

endmodule

bind id_stage id_assertions i_assertions (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .flush_i (flush_i),
  .valid_i (issue_valid_o),
  .ack_i   (issue_ack_i),
  .ready_i (fetch_ready_o),
  .pc_i    (issue_pc_o),
  .instr_i (orig_instr_o)
);

// File: sim/id_checker.sv
// Decode stage scoreboard
`timescale 1ns/1ns
`include "id_consts.svh"

module id_checker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic [2:0]           test_id_i,
  input  logic                 fetch_valid_i,
  input  logic [`ID_ILEN-1:0]  fetch_instr_i,
  input  logic [`ID_PC_W-1:0]  fetch_pc_i,
  input  logic                 fetch_ready_i,
  input  logic                 issue_ack_i,
  input  logic                 issue_valid_i,
  input  logic [`ID_PC_W-1:0]  issue_pc_i,
  input  id_pkg::fu_e          issue_fu_i,
  input  id_pkg::op_e          issue_op_i,
  input  logic [`ID_REG_W-1:0] issue_rs1_i,
  input  logic [`ID_REG_W-1:0] issue_rs2_i,
  input  logic [`ID_REG_W-1:0] issue_rd_i,
  input  logic [`ID_XLEN-1:0]  issue_imm_i,
  input  logic                 issue_illegal_i,
  input  logic                 issue_ctrl_flow_i,
  input  logic                 issue_compressed_i,
  input  logic [`ID_ILEN-1:0]  orig_instr_i,
  output int                   errors_o,
  output int                   pending_o
);
  import riscv_pkg::*;
  import id_pkg::*;

  typedef struct packed {
    logic [`ID_PC_W-1:0]  pc;
    logic [`ID_ILEN-1:0]  orig;
    logic                 comp;
    fu_e                  fu;
    op_e                  op;
    logic [`ID_REG_W-1:0] rs1;
    logic [`ID_REG_W-1:0] rs2;
    logic [`ID_REG_W-1:0] rd;
    logic [`ID_XLEN-1:0]  imm;
    logic                 ill;
    logic                 cf;
  } exp_t;

  exp_t exp_q[$];
  exp_t exp_e;
  int   error_count = 0;
  // Set after an edge that took a word into the register
  logic accepted_q = 1'b0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "alu";
      3'd1:    return "mem_branch";
      3'd2:    return "compressed";
      3'd3:    return "illegal";
      3'd4:    return "backpressure";
      default: return "flush";
    endcase
  endfunction

  function automatic op_e alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? OP_SUB : OP_ADD;
      3'd1:    return OP_SLL;
      3'd2:    return OP_SLT;
      3'd3:    return OP_SLTU;
      3'd4:    return OP_XOR;
      3'd5:    return alt ? OP_SRA : OP_SRL;
      3'd6:    return OP_OR;
      default: return OP_AND;
    endcase
  endfunction

  // --------------------
  // Reference decode
  // --------------------
  function automatic exp_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
    exp_t       e;
    logic [15:0] c;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       unk;
    e     = '0;
    e.pc  = pc;
    e.fu  = FU_NONE;
    e.op  = OP_NOP;
    c     = w[15:0];
    f7    = w[31:25];
    f3    = w[14:12];
    unk   = 1'b0;
    if (w[1:0] != 2'b11) begin
      e.comp = 1'b1;
      e.orig = {16'b0, c};
      unk    = 1'b1;
      // Decode each supported compressed form straight to its fields
      case ({c[1:0], c[15:13]})
        5'b00_010, 5'b00_110: begin
          e.fu  = c[15] ? FU_STORE : FU_LOAD;
          e.op  = c[15] ? OP_SW : OP_LW;
          e.rs1 = {2'b01, c[9:7]};
          e.rs2 = c[15] ? {2'b01, c[4:2]} : 5'd0;
          e.rd  = c[15] ? 5'd0 : {2'b01, c[4:2]};
          e.imm = {25'b0, c[5], c[12:10], c[6], 2'b00};
          unk   = 1'b0;
        end
        5'b01_000, 5'b01_010: begin
          e.fu  = FU_ALU;
          e.op  = OP_ADD;
          e.rs1 = c[14] ? 5'd0 : c[11:7];
          e.rd  = c[11:7];
          e.imm = {{26{c[12]}}, c[12], c[6:2]};
          unk   = 1'b0;
        end
        5'b01_101: begin
          e.fu  = FU_BRANCH;
          e.op  = OP_JAL;
          e.imm = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
          e.cf  = 1'b1;
          unk   = 1'b0;
        end
        5'b01_110: begin
          e.fu  = FU_BRANCH;
          e.op  = OP_BEQ;
          e.rs1 = {2'b01, c[9:7]};
          e.imm = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
          e.cf  = 1'b1;
          unk   = 1'b0;
        end
        5'b10_100: begin
          if (c[6:2] != 5'd0) begin
            e.fu  = FU_ALU;
            e.op  = OP_ADD;
            e.rs1 = c[12] ? c[11:7] : 5'd0;
            e.rs2 = c[6:2];
            e.rd  = c[11:7];
            unk   = 1'b0;
          end
        end
        default: unk = 1'b1;
      endcase
      if (c == 16'h0000) begin
        unk = 1'b1;
      end
    end else begin
      e.orig = w;
      case (w[6:0])
        OPC_LUI, OPC_AUIPC: begin
          e.fu  = FU_ALU;
          e.op  = w[5] ? OP_LUI : OP_AUIPC;
          e.rd  = w[11:7];
          e.imm = {w[31:12], 12'b0};
        end
        OPC_JAL: begin
          e.fu  = FU_BRANCH;
          e.op  = OP_JAL;
          e.rd  = w[11:7];
          e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
          e.cf  = 1'b1;
        end
        OPC_JALR: begin
          e.fu  = FU_BRANCH;
          e.op  = OP_JALR;
          e.rs1 = w[19:15];
          e.rd  = w[11:7];
          e.imm = {{20{w[31]}}, w[31:20]};
          e.cf  = 1'b1;
          unk   = (f3 != 3'd0);
        end
        OPC_BRANCH: begin
          e.fu  = FU_BRANCH;
          e.rs1 = w[19:15];
          e.rs2 = w[24:20];
          e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          e.cf  = 1'b1;
          case (f3)
            3'd0:    e.op = OP_BEQ;
            3'd1:    e.op = OP_BNE;
            3'd4:    e.op = OP_BLT;
            3'd5:    e.op = OP_BGE;
            default: unk = 1'b1;
          endcase
        end
        OPC_LOAD: begin
          e.fu  = FU_LOAD;
          e.op  = OP_LW;
          e.rs1 = w[19:15];
          e.rd  = w[11:7];
          e.imm = {{20{w[31]}}, w[31:20]};
          unk   = (f3 != 3'd2);
        end
        OPC_STORE: begin
          e.fu  = FU_STORE;
          e.op  = OP_SW;
          e.rs1 = w[19:15];
          e.rs2 = w[24:20];
          e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
          unk   = (f3 != 3'd2);
        end
        OPC_OP_IMM: begin
          e.fu  = FU_ALU;
          e.op  = alu_op(f3, f3 == 3'd5 && f7 == 7'h20);
          e.rs1 = w[19:15];
          e.rd  = w[11:7];
          e.imm = {{20{w[31]}}, w[31:20]};
          if (f3 == 3'd1) begin
            unk = (f7 != 7'h00);
          end else if (f3 == 3'd5) begin
            unk = (f7 != 7'h00 && f7 != 7'h20);
          end
        end
        OPC_OP: begin
          e.fu  = FU_ALU;
          e.op  = alu_op(f3, f7 == 7'h20);
          e.rs1 = w[19:15];
          e.rs2 = w[24:20];
          e.rd  = w[11:7];
          unk   = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        end
        default: unk = 1'b1;
      endcase
    end
    if (unk) begin
      e.fu  = FU_NONE;
      e.op  = OP_NOP;
      e.rs1 = '0;
      e.rs2 = '0;
      e.rd  = '0;
      e.imm = '0;
      e.cf  = 1'b0;
      e.ill = 1'b1;
    end
    return e;
  endfunction

  task automatic check_field(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      error_count++;
      $display("ERR test=%s field=%s expected=%h actual=%h", test_name(test_id_i), field,
               exp_v, act_v);
    end
  endtask

  // --------------------
  // Compare on issue
  // --------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // A word taken at the previous edge must be on the issue side now
      if (accepted_q && !issue_valid_i) begin
        error_count++;
        $display("Word accepted in test %s was not valid on the issue side one cycle later",
                 test_name(test_id_i));
      end
      if (flush_i) begin
        exp_q.delete();
      end else begin
        if (issue_valid_i && issue_ack_i) begin
          if (exp_q.size() == 0) begin
            error_count++;
            $display("Entry issued in test %s without a matching accepted word",
                     test_name(test_id_i));
          end else begin
            exp_e = exp_q.pop_front();
            check_field("pc", exp_e.pc, issue_pc_i);
            check_field("orig_instr", exp_e.orig, orig_instr_i);
            check_field("compressed", 32'(exp_e.comp), 32'(issue_compressed_i));
            check_field("fu", 32'(exp_e.fu), 32'(issue_fu_i));
            check_field("op", 32'(exp_e.op), 32'(issue_op_i));
            check_field("rs1", 32'(exp_e.rs1), 32'(issue_rs1_i));
            check_field("rs2", 32'(exp_e.rs2), 32'(issue_rs2_i));
            check_field("rd", 32'(exp_e.rd), 32'(issue_rd_i));
            check_field("imm", exp_e.imm, issue_imm_i);
            check_field("illegal", 32'(exp_e.ill), 32'(issue_illegal_i));
            check_field("ctrl_flow", 32'(exp_e.cf), 32'(issue_ctrl_flow_i));
          end
        end
        if (fetch_valid_i && fetch_ready_i) begin
          exp_q.push_back(ref_decode(fetch_instr_i, fetch_pc_i));
        end
      end
    end
    accepted_q = rst_ni && !flush_i && fetch_valid_i && fetch_ready_i;
    pending_o  = exp_q.size();
    errors_o   = error_count;
  end

endmodule

// File: sim/tb_id_stage.sv
// Decode stage testbench
`timescale 1ns/1ns
`include "id_consts.svh"

module tb_id_stage;
  import id_pkg::*;

  localparam int N_ALU   = 10;
  localparam int N_MEM   = 11;
  localparam int N_COMP  = 8;
  localparam int N_ILL   = 8;
  localparam int N_BP    = 40;
  localparam int N_WORDS = N_ALU + N_MEM + N_COMP + N_ILL + N_BP + 3;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 fetch_valid_i;
  logic [`ID_ILEN-1:0]  fetch_instr_i;
  logic [`ID_PC_W-1:0]  fetch_pc_i;
  logic                 fetch_ready_o;
  logic                 issue_ack_i;
  logic                 issue_valid_o;
  logic [`ID_PC_W-1:0]  issue_pc_o;
  fu_e                  issue_fu_o;
  op_e                  issue_op_o;
  logic [`ID_REG_W-1:0] issue_rs1_o;
  logic [`ID_REG_W-1:0] issue_rs2_o;
  logic [`ID_REG_W-1:0] issue_rd_o;
  logic [`ID_XLEN-1:0]  issue_imm_o;
  logic                 issue_illegal_o;
  logic                 issue_ctrl_flow_o;
  logic                 issue_compressed_o;
  logic [`ID_ILEN-1:0]  orig_instr_o;
  logic [2:0]           test_id;
  int                   chk_errors;
  int                   chk_pending;
  int                   tb_errors = 0;
  // 0 ack high, 1 random, 2 ack low, 3 driven by the test itself
  int                   ack_mode = 0;
  logic [31:0]          pc = 32'h0000_1000;
  logic [31:0]          w;

  logic [31:0] alu_vec [N_ALU] = '{32'h002081b3, 32'h407302b3, 32'h40c5d533, 32'h003130b3,
    32'h0062f233, 32'hfff00093, 32'h0641a113, 32'h7ff2c213, 32'h4033d313, 32'h01f49413};
  logic [31:0] mem_vec [N_MEM] = '{32'hffc12283, 32'h0061a423, 32'hfe208ce3, 32'h00209463,
    32'h0041c863, 32'hfe62d8e3, 32'h008000ef, 32'hffdff06f, 32'h000280e7, 32'hfffff3b7,
    32'h12345417};
  // Upper halves hold junk that must not reach orig_instr_o
  logic [31:0] comp_vec [N_COMP] = '{32'ha5a5147d, 32'h00004515, 32'h123485b2, 32'h000095b2,
    32'hffff4144, 32'h0000c504, 32'h0000bffd, 32'h5555d871};
  logic [31:0] ill_vec [N_ILL] = '{32'h00000000, 32'h00006000, 32'h00008082, 32'hbeef2002,
    32'h0000707f, 32'h02208033, 32'h00001003, 32'h0000000f};

  id_stage i_id_stage (.*);

  id_checker i_checker (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .test_id_i          (test_id),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_instr_i      (fetch_instr_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_ready_i      (fetch_ready_o),
    .issue_ack_i        (issue_ack_i),
    .issue_valid_i      (issue_valid_o),
    .issue_pc_i         (issue_pc_o),
    .issue_fu_i         (issue_fu_o),
    .issue_op_i         (issue_op_o),
    .issue_rs1_i        (issue_rs1_o),
    .issue_rs2_i        (issue_rs2_o),
    .issue_rd_i         (issue_rd_o),
    .issue_imm_i        (issue_imm_o),
    .issue_illegal_i    (issue_illegal_o),
    .issue_ctrl_flow_i  (issue_ctrl_flow_o),
    .issue_compressed_i (issue_compressed_o),
    .orig_instr_i       (orig_instr_o),
    .errors_o           (chk_errors),
    .pending_o          (chk_pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;
  end

  // --------------------
  // Ack driver
  // --------------------
  always begin
    @(posedge clk_i);
    #1;
    case (ack_mode)
      0: issue_ack_i = 1'b1;
      1: issue_ack_i = ($urandom % 3) != 0;
      2: issue_ack_i = 1'b0;
      default: ;
    endcase
  end

  initial begin
    #(N_WORDS * 20 * 8);
    $display("Timeout: the decode stage stopped accepting or issuing words");
    $display("TESTS FAILED");
    $finish;
  end

  // Called at a rising edge, returns at the accepting edge
  task automatic send_word(input logic [31:0] word);
    int waits;
    waits = 0;
    #1;
    fetch_valid_i = 1'b1;
    fetch_instr_i = word;
    fetch_pc_i    = pc;
    pc            = pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
    @(posedge clk_i);
    while (!fetch_ready_o) begin
      waits++;
      @(posedge clk_i);
    end
    if (ack_mode == 0 && waits > 0) begin
      tb_errors++;
      $display("Fetch stalled for %0d cycles while ack was held high", waits);
    end
  endtask

  task automatic drain();
    #1 fetch_valid_i = 1'b0;
    @(posedge clk_i);
    while (issue_valid_o) begin
      @(posedge clk_i);
    end
  endtask

  initial begin
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    issue_ack_i   = 1'b0;
    test_id       = 3'd0;
    void'($urandom(32'hc2c));
    wait (rst_ni);
    @(posedge clk_i);

    foreach (alu_vec[i]) send_word(alu_vec[i]);
    drain();
    test_id = 3'd1;
    foreach (mem_vec[i]) send_word(mem_vec[i]);
    drain();
    test_id = 3'd2;
    foreach (comp_vec[i]) send_word(comp_vec[i]);
    drain();
    test_id = 3'd3;
    foreach (ill_vec[i]) send_word(ill_vec[i]);
    drain();

    test_id  = 3'd4;
    ack_mode = 1;
    for (int i = 0; i < N_BP; i++) begin
      w = $urandom;
      if ($urandom % 2) begin
        w[1:0] = 2'b11;
      end
      send_word(w);
    end
    drain();

    // Flush drops the held entry and the word taken at the flush edge
    test_id  = 3'd5;
    ack_mode = 2;
    send_word(32'h00108093);
    #1 fetch_valid_i = 1'b0;
    @(posedge clk_i);
    ack_mode = 3;
    #1;
    flush_i       = 1'b1;
    issue_ack_i   = 1'b1;
    fetch_valid_i = 1'b1;
    fetch_instr_i = 32'h00210113;
    @(posedge clk_i);
    #1;
    flush_i       = 1'b0;
    issue_ack_i   = 1'b0;
    fetch_valid_i = 1'b0;
    if (issue_valid_o) begin
      tb_errors++;
      $display("Issue register still valid after a flush");
    end
    @(posedge clk_i);
    ack_mode = 0;
    send_word(32'h00318193);
    drain();
    repeat (2) @(posedge clk_i);

    if (chk_pending != 0) begin
      tb_errors++;
      $display("%0d accepted words were never issued", chk_pending);
    end
    $display("Checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/riscv_pkg.sv
verilog/id_pkg.sv
verilog/compressed_expander.sv
verilog/instr_decoder.sv
verilog/issue_register.sv
verilog/id_stage.sv
sim/id_assertions.sv
sim/id_checker.sv
sim/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_id_stage -Mdir obj_dir
./obj_dir/Vtb_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
